/* Makefile */
TOP = tb_bd_tag_split

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

# pass only when the simulation prints the pass line
run: build
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* design/bd_chan_fifo.sv */
`timescale 1ns/100ps
`include "bd_settings.svh"

module bd_chan_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = `BD_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in,
  input  logic     in_v,
  output logic     in_a,
  output payload_t out,
  output logic     out_v,
  input  logic     out_a
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

  payload_t mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic wr;
  logic rd;

  assign out_v = (count != '0);
  assign out   = mem[rd_ptr];
  // when full a read on this edge frees the slot being written
  assign in_a  = (count != full_cnt) | out_a;

  assign wr = in_v & in_a;
  assign rd = out_v & out_a;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* design/bd_pkg.sv */
`include "bd_settings.svh"

package bd_pkg;

  // word as it arrives from the chip
  typedef struct packed {
    logic [`BD_LEAF_W-1:0]    leaf_code;
    logic [`BD_PAYLOAD_W-1:0] payload;
  } raw_word_t;

  // same layout as raw_word_t, only ever holds words with a known leaf code
  typedef struct packed {
    logic [`BD_LEAF_W-1:0]    leaf_code;
    logic [`BD_PAYLOAD_W-1:0] payload;
  } decoded_word_t;

  // go-home tag word fields
  typedef struct packed {
    logic [`BD_TAG_W-1:0] tag;
    logic [`BD_CT_W-1:0]  ct;
  } tag_ct_t;

  // tag word fields, global tag in the high bits of the low payload word
  typedef struct packed {
    logic [`BD_GLOBAL_W-1:0] global_tag;
    logic [`BD_TAG_W-1:0]    tag;
    logic [`BD_CT_W-1:0]     ct;
  } global_tag_ct_t;

  // static splitter configuration
  typedef struct packed {
    // also copy go-home tag words to the other output
    logic report_tags;
  } tag_split_conf_t;

endpackage

/* design/bd_settings.svh */
`ifndef BD_SETTINGS_SVH
`define BD_SETTINGS_SVH

// word field widths
`define BD_LEAF_W 6
`define BD_PAYLOAD_W 34
`define BD_GLOBAL_W 12
`define BD_TAG_W 11
`define BD_CT_W 9

// leaf codes that carry tag words
`define BD_RO_ACC_CODE 11
`define BD_RO_TAT_CODE 12
// codes at or above this value are unknown and dropped
`define BD_NUM_LEAF_CODES 20

// global tag value that selects the go-home route
`define BD_GO_HOME_GT 0

`define BD_FIFO_DEPTH 4
`define BD_DROP_W 16

`endif

/* design/bd_tag_split.sv */
`timescale 1ns/100ps
`include "bd_settings.svh"

module bd_tag_split (
  input  bd_pkg::decoded_word_t   dec,
  input  logic                    dec_v,
  output logic                    dec_a,
  input  bd_pkg::tag_split_conf_t conf,
  output bd_pkg::tag_ct_t         tag,
  output logic                    tag_v,
  input  logic                    tag_a,
  output bd_pkg::global_tag_ct_t  glob,
  output logic                    glob_v,
  input  logic                    glob_a,
  output bd_pkg::decoded_word_t   other,
  output logic                    other_v,
  input  logic                    other_a
);

  localparam int fields_w = `BD_GLOBAL_W + `BD_TAG_W + `BD_CT_W;

  localparam logic [`BD_LEAF_W-1:0] ro_acc = `BD_LEAF_W'(`BD_RO_ACC_CODE);
  localparam logic [`BD_LEAF_W-1:0] ro_tat = `BD_LEAF_W'(`BD_RO_TAT_CODE);
  localparam logic [`BD_GLOBAL_W-1:0] go_home = `BD_GLOBAL_W'(`BD_GO_HOME_GT);

  bd_pkg::global_tag_ct_t fields;
  logic is_tag;
  logic to_glob;
  logic to_tag;
  logic to_other;
  logic tag_ok;
  logic other_ok;

  // tag fields sit in the low payload bits, the top two are ignored
  assign fields = bd_pkg::global_tag_ct_t'(dec.payload[fields_w-1:0]);

  assign is_tag = (dec.leaf_code == ro_acc) || (dec.leaf_code == ro_tat);

  // route selection
  assign to_glob  = is_tag & (fields.global_tag != go_home);
  assign to_tag   = is_tag & ~to_glob;
  assign to_other = ~is_tag | (to_tag & conf.report_tags);

  // a destination that is not used never blocks the word
  assign tag_ok   = ~to_tag | tag_a;
  assign other_ok = ~to_other | other_a;

  // payloads follow the input, v decides whether they mean anything
  always_comb begin
    glob      = fields;
    tag.tag   = fields.tag;
    tag.ct    = fields.ct;
    other     = dec;
  end

  // each queue only sees v when the whole word transfers, so nothing is
  // written to one side while the other side still stalls
  always_comb begin
    glob_v  = dec_v & to_glob;
    tag_v   = dec_v & to_tag & other_ok;
    other_v = dec_v & to_other & tag_ok;
  end

  // joint ack back to the decoder
  always_comb begin
    if (!dec_v) begin
      dec_a = 1'b0;
    end else if (to_glob) begin
      dec_a = glob_a;
    end else begin
      dec_a = tag_ok & other_ok;
    end
  end

endmodule

/* design/bd_tag_split_top.sv */
`timescale 1ns/100ps
`include "bd_settings.svh"

module bd_tag_split_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  bd_pkg::raw_word_t       raw,
  input  logic                    raw_v,
  output logic                    raw_a,
  input  bd_pkg::tag_split_conf_t conf,
  output bd_pkg::tag_ct_t         tag_out,
  output logic                    tag_v,
  input  logic                    tag_a,
  output bd_pkg::global_tag_ct_t  global_out,
  output logic                    global_v,
  input  logic                    global_a,
  output bd_pkg::decoded_word_t   other_out,
  output logic                    other_v,
  input  logic                    other_a,
  output logic [`BD_DROP_W-1:0]   drop_count
);

  // decoder to splitter
  bd_pkg::decoded_word_t decoded;
  logic decoded_v;
  logic dec_a;

  // splitter to output queues
  bd_pkg::tag_ct_t        split_tag;
  bd_pkg::global_tag_ct_t split_glob;
  bd_pkg::decoded_word_t  split_other;
  logic split_tag_v, split_tag_a;
  logic split_glob_v, split_glob_a;
  logic split_other_v, split_other_a;

  bd_word_decoder decoder_i (
    .clk(clk), .rst_n(rst_n),
    .raw(raw), .raw_v(raw_v), .raw_a(raw_a),
    .dec(decoded), .dec_v(decoded_v), .dec_a(dec_a),
    .drop_count(drop_count)
  );

  bd_tag_split split_i (
    .dec(decoded), .dec_v(decoded_v), .dec_a(dec_a), .conf(conf),
    .tag(split_tag), .tag_v(split_tag_v), .tag_a(split_tag_a),
    .glob(split_glob), .glob_v(split_glob_v), .glob_a(split_glob_a),
    .other(split_other), .other_v(split_other_v), .other_a(split_other_a)
  );

  bd_chan_fifo #(.payload_t(bd_pkg::tag_ct_t)) tag_fifo_i (
    .clk(clk), .rst_n(rst_n),
    .in(split_tag), .in_v(split_tag_v), .in_a(split_tag_a),
    .out(tag_out), .out_v(tag_v), .out_a(tag_a)
  );

  bd_chan_fifo #(.payload_t(bd_pkg::global_tag_ct_t)) global_fifo_i (
    .clk(clk), .rst_n(rst_n),
    .in(split_glob), .in_v(split_glob_v), .in_a(split_glob_a),
    .out(global_out), .out_v(global_v), .out_a(global_a)
  );

  bd_chan_fifo #(.payload_t(bd_pkg::decoded_word_t)) other_fifo_i (
    .clk(clk), .rst_n(rst_n),
    .in(split_other), .in_v(split_other_v), .in_a(split_other_a),
    .out(other_out), .out_v(other_v), .out_a(other_a)
  );

endmodule

/* design/bd_word_decoder.sv */
`timescale 1ns/100ps
`include "bd_settings.svh"

module bd_word_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  input  bd_pkg::raw_word_t       raw,
  input  logic                    raw_v,
  output logic                    raw_a,
  output bd_pkg::decoded_word_t   dec,
  output logic                    dec_v,
  input  logic                    dec_a,
  output logic [`BD_DROP_W-1:0]   drop_count
);

  localparam logic [`BD_LEAF_W-1:0] num_codes = `BD_LEAF_W'(`BD_NUM_LEAF_CODES);
  localparam logic [`BD_DROP_W-1:0] drop_max = {`BD_DROP_W{1'b1}};

  logic known;
  logic take;
  logic take_known;
  logic take_drop;

  assign known = (raw.leaf_code < num_codes);

  // free slot, or the held word leaves on this edge
  assign raw_a = ~dec_v | dec_a;

  assign take       = raw_v & raw_a;
  assign take_known = take & known;
  assign take_drop  = take & ~known;

  // occupancy of the single stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_v <= 1'b0;
    end else if (take_known) begin
      dec_v <= 1'b1;
    end else if (dec_a) begin
      dec_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_known) begin
      dec.leaf_code <= raw.leaf_code;
      dec.payload   <= raw.payload;
    end
  end

  // unknown words are acked and only counted, counter sticks at max
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (take_drop && drop_count != drop_max) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

/* list.f */
+incdir+design
+incdir+tests
design/bd_pkg.sv
design/bd_chan_fifo.sv
design/bd_word_decoder.sv
design/bd_tag_split.sv
design/bd_tag_split_top.sv
tests/tb_bd_tag_split.sv

/* tests/tb_bd_checks.svh */
`ifndef TB_BD_CHECKS_SVH
`define TB_BD_CHECKS_SVH

function automatic logic ack_for(input int mode);
  int r;
  r = $random(seed);
  if (mode == ack_random) begin
    return r[0];
  end
  return (mode == ack_on);
endfunction

function automatic bd_pkg::raw_word_t plain_word(input int leaf,
                                                 input logic [`BD_PAYLOAD_W-1:0] payload);
  bd_pkg::raw_word_t w;
  w.leaf_code = `BD_LEAF_W'(leaf);
  w.payload = payload;
  return w;
endfunction

// tag word, global tag above tag above ct in the low payload bits
function automatic bd_pkg::raw_word_t tag_word(input int leaf, input int top, input int gt,
                                               input int tg, input int ct);
  bd_pkg::raw_word_t w;
  w.leaf_code = `BD_LEAF_W'(leaf);
  w.payload = {top_w'(top), `BD_GLOBAL_W'(gt), `BD_TAG_W'(tg), `BD_CT_W'(ct)};
  return w;
endfunction

function automatic bd_pkg::raw_word_t random_word();
  int r;
  int leaf;
  r = $random(seed);
  case (r & 7)
    0, 1: leaf = `BD_RO_ACC_CODE;
    2, 3: leaf = `BD_RO_TAT_CODE;
    4: leaf = 0;
    5: leaf = 7;
    6: leaf = 19;
    default: leaf = 42;
  endcase
  // global tag kept in 0..3 so go-home words show up often
  return tag_word(leaf, (r >> 30) & 3, (r >> 3) & 3, (r >> 5) & 2047, (r >> 16) & 511);
endfunction

function automatic logic outputs_done();
  return tag_got.size() >= tag_exp.size() && global_got.size() >= global_exp.size()
         && other_got.size() >= other_exp.size();
endfunction

// reference routing of one raw word
task automatic expect_routes(input bd_pkg::raw_word_t w);
  bd_pkg::global_tag_ct_t g;
  bd_pkg::tag_ct_t t;
  bd_pkg::decoded_word_t d;
  d.leaf_code = w.leaf_code;
  d.payload = w.payload;
  g.global_tag = w.payload[fields_w-1 -: `BD_GLOBAL_W];
  g.tag = w.payload[`BD_TAG_W+`BD_CT_W-1 -: `BD_TAG_W];
  g.ct = w.payload[`BD_CT_W-1:0];
  t.tag = g.tag;
  t.ct = g.ct;
  if (w.leaf_code >= leaf_limit) begin
    drops_exp = drops_exp + 1'b1;
  end else if (w.leaf_code != ro_acc && w.leaf_code != ro_tat) begin
    other_exp.push_back(d);
  end else if (g.global_tag != go_home) begin
    global_exp.push_back(g);
  end else begin
    tag_exp.push_back(t);
    if (conf.report_tags) begin
      other_exp.push_back(d);
    end
  end
endtask

task automatic report_error(input string msg);
  $display("error at %0t: %s", $time, msg);
  test_errors++;
endtask

task automatic compare_tag(input string name, input bd_pkg::tag_ct_t got,
                           input bd_pkg::tag_ct_t exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    test_errors++;
  end
endtask

task automatic compare_global(input string name, input bd_pkg::global_tag_ct_t got,
                              input bd_pkg::global_tag_ct_t exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    test_errors++;
  end
endtask

task automatic compare_other(input string name, input bd_pkg::decoded_word_t got,
                             input bd_pkg::decoded_word_t exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    test_errors++;
  end
endtask

task automatic compare_drops(input logic [`BD_DROP_W-1:0] got,
                             input logic [`BD_DROP_W-1:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t: drop_count rise got %0d expected %0d", $time, got, exp);
    test_errors++;
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    report_error($sformatf("%s received %0d words, expected %0d", name, got, exp));
  end
endtask

// present one word and hold it until raw_a is seen high
task automatic send_word(input bd_pkg::raw_word_t w);
  int waited;
  expect_routes(w);
  @(negedge clk);
  raw = w;
  raw_v = 1'b1;
  #(quarter);
  waited = 0;
  while (!raw_a && waited < wait_limit) begin
    @(negedge clk);
    #(quarter);
    waited++;
  end
  if (!raw_a) begin
    report_error("raw_a stayed low, word was not accepted");
  end
endtask

task automatic end_burst();
  @(negedge clk);
  raw_v = 1'b0;
endtask

task automatic check_stall();
  int waited;
  waited = 0;
  @(negedge clk);
  #(quarter);
  while (raw_a && waited < wait_limit) begin
    @(negedge clk);
    #(quarter);
    waited++;
  end
  if (raw_a) begin
    report_error("raw_a did not fall while other_a was held low");
  end
endtask

task automatic start_test(input string name, input logic report);
  @(negedge clk);
  test_name = name;
  conf.report_tags = report;
  tag_mode = ack_on;
  global_mode = ack_on;
  other_mode = ack_on;
  tag_exp.delete();
  tag_got.delete();
  global_exp.delete();
  global_got.delete();
  other_exp.delete();
  other_got.delete();
  drops_exp = '0;
  drop_base = drop_count;
  test_errors = 0;
endtask

task automatic finish_test();
  int waited;
  int i;
  end_burst();
  waited = 0;
  while (!outputs_done() && waited < wait_limit) begin
    @(negedge clk);
    waited++;
  end
  if (!outputs_done()) begin
    report_error("timed out waiting for output words");
  end
  // extra cycles so a stray or repeated word would be caught
  repeat (settle) @(negedge clk);
  check_count("tag_out", tag_got.size(), tag_exp.size());
  check_count("global_out", global_got.size(), global_exp.size());
  check_count("other_out", other_got.size(), other_exp.size());
  for (i = 0; i < tag_got.size() && i < tag_exp.size(); i++) begin
    compare_tag($sformatf("tag_out word %0d", i), tag_got[i], tag_exp[i]);
  end
  for (i = 0; i < global_got.size() && i < global_exp.size(); i++) begin
    compare_global($sformatf("global_out word %0d", i), global_got[i], global_exp[i]);
  end
  for (i = 0; i < other_got.size() && i < other_exp.size(); i++) begin
    compare_other($sformatf("other_out word %0d", i), other_got[i], other_exp[i]);
  end
  compare_drops(drop_count - drop_base, drops_exp);
  if (test_errors == 0) begin
    $display("%s: passed", test_name);
  end else begin
    $display("%s: failed with %0d errors", test_name, test_errors);
    tests_failed++;
  end
  total_errors += test_errors;
  tests_run++;
endtask

task automatic pass_through_other();
  start_test("other words", 1'b0);
  send_word(plain_word(0, 34'h0_0000_0001));
  send_word(plain_word(5, 34'h3_ffff_ffff));
  send_word(plain_word(10, 34'h1_2345_6789));
  send_word(plain_word(13, 34'h2_dead_beef));
  send_word(plain_word(19, 34'h0_a5a5_5a5a));
  finish_test();
endtask

task automatic send_go_home_set();
  send_word(tag_word(`BD_RO_ACC_CODE, 0, 0, 2047, 0));
  send_word(tag_word(`BD_RO_TAT_CODE, 3, 0, 5, 511));
  send_word(tag_word(`BD_RO_ACC_CODE, 1, 0, 1024, 256));
  send_word(tag_word(`BD_RO_TAT_CODE, 2, 0, 0, 1));
endtask

task automatic route_go_home();
  start_test("go-home tags", 1'b0);
  send_go_home_set();
  finish_test();
endtask

task automatic copy_go_home();
  start_test("go-home tags reported", 1'b1);
  send_go_home_set();
  finish_test();
endtask

task automatic route_global(input logic report);
  start_test($sformatf("global tags, report_tags %0d", report), report);
  send_word(tag_word(`BD_RO_ACC_CODE, 0, 1, 3, 7));
  send_word(tag_word(`BD_RO_TAT_CODE, 3, 4095, 2047, 511));
  send_word(tag_word(`BD_RO_ACC_CODE, 2, 2048, 0, 0));
  send_word(tag_word(`BD_RO_TAT_CODE, 1, 165, 341, 170));
  finish_test();
endtask

// other queue fills, the fifth other word parks in the decoder
task automatic stall_and_release();
  start_test("back-pressure on other", 1'b0);
  other_mode = ack_off;
  send_word(plain_word(3, 34'h0_0000_0003));
  send_word(tag_word(`BD_RO_ACC_CODE, 0, 0, 17, 33));
  send_word(plain_word(7, 34'h1_0000_0007));
  send_word(tag_word(`BD_RO_TAT_CODE, 0, 9, 18, 34));
  send_word(plain_word(9, 34'h2_0000_0009));
  send_word(tag_word(`BD_RO_TAT_CODE, 0, 0, 19, 35));
  send_word(plain_word(14, 34'h3_0000_000e));
  send_word(plain_word(18, 34'h0_1234_0012));
  end_burst();
  check_stall();
  other_mode = ack_on;
  send_word(plain_word(2, 34'h0_5555_0002));
  send_word(tag_word(`BD_RO_ACC_CODE, 1, 77, 20, 36));
  finish_test();
endtask

task automatic random_ack_burst();
  int n;
  start_test("random acks", 1'b1);
  tag_mode = ack_random;
  global_mode = ack_random;
  other_mode = ack_random;
  for (n = 0; n < 40; n++) begin
    send_word(random_word());
  end
  finish_test();
endtask

task automatic drop_unknown();
  start_test("unknown leaf codes", 1'b0);
  send_word(plain_word(20, 34'h0_0000_0014));
  send_word(plain_word(21, 34'h1_ffff_0000));
  send_word(plain_word(33, 34'h2_0f0f_0f0f));
  send_word(plain_word(47, 34'h3_8000_0001));
  send_word(plain_word(63, 34'h0_7777_7777));
  finish_test();
endtask

`endif

/* tests/tb_bd_tag_split.sv */
`timescale 1ns/100ps
`include "bd_settings.svh"

module tb_bd_tag_split;

  localparam int quarter = 25;
  localparam int wait_limit = 300;
  localparam int settle = 8;
  localparam int run_limit = 3000000;
  localparam int ack_on = 0;
  localparam int ack_random = 1;
  localparam int ack_off = 2;
  localparam int fields_w = `BD_GLOBAL_W + `BD_TAG_W + `BD_CT_W;
  localparam int top_w = `BD_PAYLOAD_W - fields_w;
  localparam logic [`BD_LEAF_W-1:0] leaf_limit = `BD_LEAF_W'(`BD_NUM_LEAF_CODES);
  localparam logic [`BD_LEAF_W-1:0] ro_acc = `BD_LEAF_W'(`BD_RO_ACC_CODE);
  localparam logic [`BD_LEAF_W-1:0] ro_tat = `BD_LEAF_W'(`BD_RO_TAT_CODE);
  localparam logic [`BD_GLOBAL_W-1:0] go_home = `BD_GLOBAL_W'(`BD_GO_HOME_GT);

  // starts low before any process runs, so time zero has no falling edge
  logic clk = 1'b0;
  logic rst_n;
  bd_pkg::raw_word_t raw;
  logic raw_v;
  logic raw_a;
  bd_pkg::tag_split_conf_t conf;
  bd_pkg::tag_ct_t tag_out;
  logic tag_v;
  logic tag_a;
  bd_pkg::global_tag_ct_t global_out;
  logic global_v;
  logic global_a;
  bd_pkg::decoded_word_t other_out;
  logic other_v;
  logic other_a;
  logic [`BD_DROP_W-1:0] drop_count;

  integer seed = 25;
  int tag_mode = ack_on;
  int global_mode = ack_on;
  int other_mode = ack_on;

  // expected and received words per output
  bd_pkg::tag_ct_t tag_exp[$];
  bd_pkg::tag_ct_t tag_got[$];
  bd_pkg::global_tag_ct_t global_exp[$];
  bd_pkg::global_tag_ct_t global_got[$];
  bd_pkg::decoded_word_t other_exp[$];
  bd_pkg::decoded_word_t other_got[$];
  logic [`BD_DROP_W-1:0] drops_exp;
  logic [`BD_DROP_W-1:0] drop_base;

  string test_name;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;

  `include "tb_bd_checks.svh"

  bd_tag_split_top bd_tag_split_top_i (
    .clk(clk), .rst_n(rst_n),
    .raw(raw), .raw_v(raw_v), .raw_a(raw_a), .conf(conf),
    .tag_out(tag_out), .tag_v(tag_v), .tag_a(tag_a),
    .global_out(global_out), .global_v(global_v), .global_a(global_a),
    .other_out(other_out), .other_v(other_v), .other_a(other_a),
    .drop_count(drop_count)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // output sinks move their acks on the falling edge and take a word
  // at the next rising edge when v and a are both high
  initial begin
    forever begin
      @(negedge clk);
      tag_a    = ack_for(tag_mode);
      global_a = ack_for(global_mode);
      other_a  = ack_for(other_mode);
      #(quarter);
      if (tag_v && tag_a) begin
        tag_got.push_back(tag_out);
      end
      if (global_v && global_a) begin
        global_got.push_back(global_out);
      end
      if (other_v && other_a) begin
        other_got.push_back(other_out);
      end
    end
  end

  initial begin
    #(run_limit);
    $display("error: simulation did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    raw = '0;
    raw_v = 1'b0;
    conf = '0;
    tag_a = 1'b1;
    global_a = 1'b1;
    other_a = 1'b1;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (tag_v || global_v || other_v || drop_count != '0) begin
      $display("error: outputs not idle after reset");
      total_errors++;
    end
    pass_through_other();
    route_go_home();
    copy_go_home();
    route_global(1'b0);
    route_global(1'b1);
    stall_and_release();
    random_ack_burst();
    drop_unknown();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
